// ==== Bender.yml ====
package:
  name: correlator_block

sources:
  # Packages first, then RTL in dependency order
  - files:
      - src/corr_cfg_pkg.sv
      - src/corr_types_pkg.sv
      - src/corr_pair_decode.sv
      - src/corr_mac_lane.sv
      - src/vis_buffer.sv
      - src/correlator_block.sv
  - target: simulation
    files:
      - sim/correlator_block_asserts.sv
      - sim/tb_correlator_block.sv

// ==== sim/correlator_block_asserts.sv ====
`timescale 1ns/1ps

module correlator_block_asserts (
   input logic                     clk_x,
   input logic                     rst,
   input corr_types_pkg::bus_req_t bus_i,
   input logic                     bus_ack_o,
   input logic                     overflow_cos_o,
   input logic                     overflow_sin_o
);

   int err_cnt = 0;   // Failed assertions so far

   // --------------------
   // Bus handshake
   // --------------------
   ack_pulse: assert property (@(posedge clk_x) disable iff (rst)
      bus_ack_o |=> !bus_ack_o)
      else begin
         $error("bus_ack_o high for more than one cycle");
         err_cnt++;
      end

   ack_latency: assert property (@(posedge clk_x) disable iff (rst)
      bus_i.stb |-> ##3 bus_ack_o)                 // Capture, read, then ack
      else begin
         $error("bus_ack_o missing after strobe");
         err_cnt++;
      end

   // Reset leaves ack and flags low
   reset_idle: assert property (@(posedge clk_x)
      rst |=> !bus_ack_o && !overflow_cos_o && !overflow_sin_o)
      else begin
         $error("outputs not idle after reset");
         err_cnt++;
      end

   // --------------------
   // Sticky overflow
   // --------------------
   cos_sticky: assert property (@(posedge clk_x) disable iff (rst)
      overflow_cos_o |=> overflow_cos_o)
      else begin
         $error("overflow_cos_o dropped outside reset");
         err_cnt++;
      end

   sin_sticky: assert property (@(posedge clk_x) disable iff (rst)
      overflow_sin_o |=> overflow_sin_o)
      else begin
         $error("overflow_sin_o dropped outside reset");
         err_cnt++;
      end

endmodule

bind correlator_block correlator_block_asserts correlator_block_asserts_inst (.*);

// ==== sim/tb_correlator_block.sv ====
`timescale 1ns/1ps

module tb_correlator_block;

   import corr_cfg_pkg::*;
   import corr_types_pkg::*;

   localparam logic [31:0] SEED         = 32'ha4c4f60c;
   localparam int          RESET_CYCLES = 5;
   localparam int          ACK_TIMEOUT  = 8;     // Edges allowed for one bus read
   localparam int          DRAIN_CYCLES = 3;     // Decode, lane, buffer
   localparam int          ACC_MAX      = 2 ** (ACCUM_BITS - 1) - 1;
   localparam int          ACC_MIN      = -(2 ** (ACCUM_BITS - 1));

   logic        clk_x;
   logic        rst;
   logic        en_i;
   ant_sample_t sample_i;
   logic        sw_i;
   bus_req_t    bus_i;
   logic        bus_ack_o;
   bus_word_t   bus_dat_o;
   logic        overflow_cos_o;
   logic        overflow_sin_o;

   // --------------------
   // Reference model state
   // --------------------
   logic [31:0] rnd_state;
   int          m_slot;
   logic        m_pend;
   logic        m_bank;                          // Bank being written
   logic        m_clear;
   logic [1:0]  m_ovf;                           // Sticky flags as {cos, sin}
   vis_pair_t   acc_m   [MRATE][LANES];          // Per slot sums as kept in the lanes
   vis_pair_t   exp_mem [2][MRATE][LANES];       // Expected buffer contents
   logic        exp_set [2][MRATE][LANES];       // Word written at least once

   correlator_block correlator_block_inst (.*);

   initial begin
      clk_x = 1'b0;
      forever #10 clk_x = ~clk_x;                // 20 ns period
   end

   function automatic logic [31:0] next_random();
      rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
      return rnd_state;
   endfunction

   // Sign bit 1 is +1 and 0 is -1
   function automatic int sgn(input logic b);
      return b ? 1 : -1;
   endfunction

   // One sampled cycle of decode and lanes with a times conj(b) per lane
   function automatic void model_step(input logic en, input ant_sample_t s, input logic sw);
      pair_t     pr;
      vis_pair_t base;
      int        re;
      int        im;
      int        cs;
      int        sn;
      logic      wrap;
      logic      swap;
      if (en) begin
         for (int l = 0; l < LANES; l++) begin
            pr   = PAIR_TABLE[m_slot][l];
            re   = sgn(s.re[pr.a]) * sgn(s.re[pr.b]) + sgn(s.im[pr.a]) * sgn(s.im[pr.b]);
            im   = sgn(s.im[pr.a]) * sgn(s.re[pr.b]) - sgn(s.re[pr.a]) * sgn(s.im[pr.b]);
            base = m_clear ? '0 : acc_m[m_slot][l];
            cs   = int'(base.cos) + re;           // Full precision sums
            sn   = int'(base.sin) + im;
            if (cs > ACC_MAX || cs < ACC_MIN) m_ovf[1] = 1'b1;
            if (sn > ACC_MAX || sn < ACC_MIN) m_ovf[0] = 1'b1;
            acc_m[m_slot][l].cos = ACCUM_BITS'(cs);   // Wrap to accumulator width
            acc_m[m_slot][l].sin = ACCUM_BITS'(sn);
            exp_mem[m_bank][m_slot][l] = acc_m[m_slot][l];
            exp_set[m_bank][m_slot][l] = 1'b1;
         end
      end
      wrap = en && (m_slot == MRATE - 1);
      swap = wrap && (sw || m_pend);
      if (!en || swap) m_clear = 1'b1;            // Idle cycle or new bank
      else if (wrap) m_clear = 1'b0;
      if (swap) begin
         m_pend = 1'b0;
         m_bank = ~m_bank;
      end else if (sw) begin
         m_pend = 1'b1;                          // Waits for the wrap
      end
      if (wrap) m_slot = 0;
      else if (en) m_slot++;
   endfunction

   // --------------------
   // Checks
   // --------------------
   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "Testbench stopped at first error");
   endtask

   task automatic check_vis_word(input bus_word_t got, input bus_word_t exp, input string what);
      if (got !== exp) begin
         stop_with_failure($sformatf("CHECK FAILED at %0t: %s read %0d expected %0d",
                                     $time, what, $signed(got), $signed(exp)));
      end
   endtask

   task automatic check_overflow(input logic [1:0] got, input logic [1:0] exp, input string what);
      if (got !== exp) begin
         stop_with_failure($sformatf("CHECK FAILED at %0t: %s overflow {cos,sin} %b expected %b",
                                     $time, what, got, exp));
      end
   endtask

   // Bound assertion failures end the run at once
   always @(negedge clk_x) begin
      if (correlator_block_inst.correlator_block_asserts_inst.err_cnt != 0) begin
         stop_with_failure("Bound assertions on the DUT reported a failure");
      end
   end

   // --------------------
   // Stimulus
   // --------------------
   task automatic drive_cycle(input logic en, input ant_sample_t s, input logic sw);
      @(posedge clk_x);
      en_i     <= en;
      sample_i <= s;
      sw_i     <= sw;
      model_step(en, s, sw);                     // Sampled by the DUT next edge
   endtask

   // Random or all-ones samples with optional idle gaps
   task automatic run_cycles(input int n, input logic gaps, input logic ones);
      logic [31:0] r;
      logic        en;
      ant_sample_t s;
      for (int i = 0; i < n; i++) begin
         r  = next_random();
         en = !gaps || (r[7:5] != 3'd0);         // About one idle in eight
         if (ones) s = '1;
         else s = r[31:16];
         drive_cycle(en, s, 1'b0);
      end
   endtask

   // Pulse sw_i in slot sw_slot and run on to the swap, then let the pipeline empty
   task automatic switch_at_slot(input int sw_slot);
      for (int i = 0; i < MRATE && m_slot != sw_slot; i++) begin
         drive_cycle(1'b1, 16'(next_random() >> 16), 1'b0);
      end
      drive_cycle(1'b1, 16'(next_random() >> 16), 1'b1);
      for (int i = 0; i < MRATE && m_slot != 0; i++) begin
         drive_cycle(1'b1, 16'(next_random() >> 16), 1'b0);
      end
      if (m_slot != 0) stop_with_failure("Slot counter never returned to slot 0 after a switch");
      for (int i = 0; i < DRAIN_CYCLES; i++) begin
         drive_cycle(1'b0, '0, 1'b0);
      end
   endtask

   // Ack comes two edges after the strobe and is sampled on the falling edge
   task automatic bus_read(input logic [BUS_ADDR_BITS-1:0] adr, output bus_word_t dat);
      int waited;
      @(posedge clk_x);
      bus_i.stb <= 1'b1;
      bus_i.adr <= adr;
      @(posedge clk_x);
      bus_i.stb <= 1'b0;
      waited = 0;
      @(negedge clk_x);
      while (!bus_ack_o) begin
         if (waited == ACK_TIMEOUT) begin
            stop_with_failure($sformatf("Timeout waiting for bus ack, address %0d", adr));
         end
         @(negedge clk_x);
         waited++;
      end
      dat = bus_dat_o;
   endtask

   // Every written word of the idle bank with word 0 cosine and word 1 sine
   task automatic read_inactive_bank(input string phase);
      logic [BUS_ADDR_BITS-1:0] adr;
      logic                     rb;
      bus_word_t                got;
      bus_word_t                exp;
      rb = ~m_bank;
      for (int s = 0; s < MRATE; s++) begin
         for (int l = 0; l < LANES; l++) begin
            for (int w = 0; w < 2; w++) begin
               if (exp_set[rb][s][l]) begin
                  adr = {SLOT_BITS'(s), LANE_BITS'(l), 1'(w)};
                  bus_read(adr, got);
                  exp = (w == 1) ? exp_mem[rb][s][l].sin : exp_mem[rb][s][l].cos;
                  check_vis_word(got, exp, $sformatf("%s bank %0d slot %0d lane %0d word %0d",
                                                     phase, rb, s, l, w));
               end
            end
         end
      end
      @(negedge clk_x);
      check_overflow({overflow_cos_o, overflow_sin_o}, m_ovf, phase);
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      rnd_state = SEED;
      m_slot    = 0;
      m_pend    = 1'b0;
      m_bank    = 1'b0;
      m_clear   = 1'b1;
      m_ovf     = 2'b00;
      exp_set   = '{default: 1'b0};
      rst       = 1'b1;
      en_i      = 1'b0;
      sample_i  = '0;
      sw_i      = 1'b0;
      bus_i     = '0;
      repeat (RESET_CYCLES) @(posedge clk_x);
      rst <= 1'b0;

      run_cycles(6 * MRATE, 1'b0, 1'b0);         // Plain accumulation
      switch_at_slot(MRATE - 1);                 // Request in the wrap cycle itself
      read_inactive_bank("accumulation");

      run_cycles(5 * MRATE, 1'b0, 1'b0);         // Old sums must not carry over
      switch_at_slot(0);
      read_inactive_bank("bank clearing");

      run_cycles(3 * MRATE, 1'b0, 1'b0);
      switch_at_slot(1);                         // Slots 2 and 3 stay in the old bank
      read_inactive_bank("switch timing");

      run_cycles(40, 1'b1, 1'b0);                // Idle gaps force a clear
      switch_at_slot(2);
      read_inactive_bank("en gaps");

      run_cycles(70 * MRATE, 1'b0, 1'b1);        // Cosine climbs by 2 per pass
      switch_at_slot(MRATE - 1);
      read_inactive_bank("overflow");

      run_cycles(2 * MRATE, 1'b0, 1'b0);         // Flags stay set
      switch_at_slot(0);
      read_inactive_bank("overflow sticky");

      if (correlator_block_inst.correlator_block_asserts_inst.err_cnt != 0) begin
         stop_with_failure("Bound assertions on the DUT reported failures");
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

// ==== src/corr_cfg_pkg.sv ====
package corr_cfg_pkg;

   // --------------------
   // Array sizes
   // --------------------
   localparam int N_ANT      = 8;          // Antennas, one sample bit each for re and im
   localparam int ANT_BITS   = 3;          // Antenna index width
   localparam int MRATE      = 4;          // Time slots per pass, must be 2 or more
   localparam int SLOT_BITS  = 2;          // Slot index width
   localparam int LANES      = 2;          // Parallel correlator lanes
   localparam int LANE_BITS  = 1;          // Lane index width
   localparam int ACCUM_BITS = 8;          // Accumulator and bus word width

   // Bus address is {slot, lane, word select}
   localparam int BUS_ADDR_BITS = SLOT_BITS + LANE_BITS + 1;

   // One table entry, antenna a times conj(antenna b)
   typedef struct packed {
      logic [ANT_BITS-1:0] a;
      logic [ANT_BITS-1:0] b;
   } pair_t;

   // --------------------
   // Baseline schedule
   // --------------------
   // Row is the slot, column the lane
   // Four slots of two lanes cover eight baselines per pass
   localparam pair_t PAIR_TABLE [MRATE][LANES] = '{
      '{'{a: 3'd0, b: 3'd1}, '{a: 3'd2, b: 3'd3}},   // Slot 0, adjacent pairs
      '{'{a: 3'd4, b: 3'd5}, '{a: 3'd6, b: 3'd7}},   // Slot 1
      '{'{a: 3'd0, b: 3'd2}, '{a: 3'd1, b: 3'd3}},   // Slot 2, spacing of two
      '{'{a: 3'd4, b: 3'd6}, '{a: 3'd5, b: 3'd7}}    // Slot 3
   };

endpackage

// ==== src/corr_mac_lane.sv ====
`timescale 1ns/1ps

module corr_mac_lane #(
   parameter int LANE = 0                         // Column of the pair table
) (
   input  logic                          clk_x,
   input  logic                          rst,
   input  corr_types_pkg::corr_op_t      op_i,
   output corr_types_pkg::lane_result_t  res_o,
   output logic                          ovf_cos_o,   // Sticky
   output logic                          ovf_sin_o    // Sticky
);

   import corr_cfg_pkg::*;
   import corr_types_pkg::*;

   lane_bits_t                   bits;
   logic signed [2:0]            p_rr;      // re_a * re_b
   logic signed [2:0]            p_ii;      // im_a * im_b
   logic signed [2:0]            p_ir;      // im_a * re_b
   logic signed [2:0]            p_ri;      // re_a * im_b
   logic signed [2:0]            re_part;
   logic signed [2:0]            im_part;
   logic signed [ACCUM_BITS-1:0] add_cos;
   logic signed [ACCUM_BITS-1:0] add_sin;
   vis_pair_t                    acc_q [MRATE];   // One pair per slot
   vis_pair_t                    base;
   vis_pair_t                    sum;
   logic                         cos_wrap;
   logic                         sin_wrap;

   // Bit 1 is +1 and bit 0 is -1, so the product is +1 when bits agree
   function automatic logic signed [2:0] sgn_mul(input logic x, input logic y);
      return (x ~^ y) ? 3'sd1 : -3'sd1;
   endfunction

   // --------------------
   // One-bit complex product
   // --------------------
   assign bits = op_i.lane[LANE];

   assign p_rr = sgn_mul(bits.re_a, bits.re_b);
   assign p_ii = sgn_mul(bits.im_a, bits.im_b);
   assign p_ir = sgn_mul(bits.im_a, bits.re_b);
   assign p_ri = sgn_mul(bits.re_a, bits.im_b);

   // a * conj(b), each part in {-2, 0, 2}
   assign re_part = p_rr + p_ii;
   assign im_part = p_ir - p_ri;

   // Sign extend to accumulator width
   assign add_cos = {{(ACCUM_BITS-3){re_part[2]}}, re_part};
   assign add_sin = {{(ACCUM_BITS-3){im_part[2]}}, im_part};

   // --------------------
   // Accumulate
   // --------------------
   // Same slot comes back only after MRATE cycles, read then write is safe
   assign base = op_i.clear ? '0 : acc_q[op_i.slot];

   always_comb begin
      sum.cos = base.cos + add_cos;   // Two's complement wrap
      sum.sin = base.sin + add_sin;
   end

   // Signed overflow when both operands agree in sign and the sum does not
   assign cos_wrap = (base.cos[ACCUM_BITS-1] == add_cos[ACCUM_BITS-1]) &&
                     (sum.cos[ACCUM_BITS-1] != base.cos[ACCUM_BITS-1]);
   assign sin_wrap = (base.sin[ACCUM_BITS-1] == add_sin[ACCUM_BITS-1]) &&
                     (sum.sin[ACCUM_BITS-1] != base.sin[ACCUM_BITS-1]);

   always_ff @(posedge clk_x) begin
      if (op_i.valid) begin
         acc_q[op_i.slot] <= sum;
      end
   end

   // Result for the buffer, written through the pair view
   always_ff @(posedge clk_x) begin
      res_o.valid    <= op_i.valid;
      res_o.slot     <= op_i.slot;
      res_o.bank     <= op_i.bank;
      res_o.vis.pair <= sum;
      if (rst) begin
         res_o.valid <= 1'b0;
      end
   end

   // --------------------
   // Overflow flags
   // --------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         ovf_cos_o <= 1'b0;
         ovf_sin_o <= 1'b0;
      end else if (op_i.valid) begin
         ovf_cos_o <= ovf_cos_o | cos_wrap;   // Only reset clears
         ovf_sin_o <= ovf_sin_o | sin_wrap;
      end
   end

endmodule

// ==== src/corr_pair_decode.sv ====
`timescale 1ns/1ps

module corr_pair_decode (
   input  logic                        clk_x,
   input  logic                        rst,
   input  logic                        en_i,       // Samples valid this cycle
   input  corr_types_pkg::ant_sample_t sample_i,
   input  logic                        sw_i,       // Bank switch request, one cycle
   output corr_types_pkg::corr_op_t    op_o,
   output logic                        rd_bank_o   // Bank the bus may read
);

   import corr_cfg_pkg::*;
   import corr_types_pkg::*;

   logic [SLOT_BITS-1:0] slot_q;
   logic                 pend_q;    // Switch seen, waiting for the wrap
   logic                 bank_q;    // Bank being written
   logic                 clear_q;   // Current pass starts from zero
   logic                 wrap;      // Enabled cycle in the last slot
   logic                 swap;      // Bank toggles at this wrap
   corr_op_t             op_d;

   assign wrap = en_i && (slot_q == SLOT_BITS'(MRATE - 1));
   assign swap = wrap && (sw_i || pend_q);

   // --------------------
   // Slot sequencer
   // --------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         slot_q <= '0;
      end else if (wrap) begin
         slot_q <= '0;
      end else if (en_i) begin
         slot_q <= slot_q + 1'b1;   // Holds while en_i is low
      end
   end

   // --------------------
   // Bank and clear control
   // --------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         pend_q <= 1'b0;
         bank_q <= 1'b0;
      end else begin
         if (swap) begin
            pend_q <= 1'b0;         // Request consumed
            bank_q <= ~bank_q;      // New bank from the next slot 0
         end else if (sw_i) begin
            pend_q <= 1'b1;
         end
      end
   end

   // A gap in en_i restarts the sums as well
   always_ff @(posedge clk_x) begin
      if (rst || !en_i) begin
         clear_q <= 1'b1;
      end else if (swap) begin
         clear_q <= 1'b1;           // Whole next pass starts from zero
      end else if (wrap) begin
         clear_q <= 1'b0;           // Clearing pass done
      end
   end

   // --------------------
   // Pair lookup
   // --------------------
   always_comb begin
      pair_t pa;
      op_d       = '0;
      op_d.valid = en_i;
      op_d.slot  = slot_q;
      op_d.bank  = bank_q;
      op_d.clear = clear_q;
      for (int l = 0; l < LANES; l++) begin
         pa = PAIR_TABLE[slot_q][l];
         op_d.lane[l].re_a = sample_i.re[pa.a];
         op_d.lane[l].im_a = sample_i.im[pa.a];
         op_d.lane[l].re_b = sample_i.re[pa.b];
         op_d.lane[l].im_b = sample_i.im[pa.b];
      end
   end

   // Registered op, only valid is cleared by reset
   always_ff @(posedge clk_x) begin
      op_o <= op_d;
      if (rst) begin
         op_o.valid <= 1'b0;
      end
   end

   assign rd_bank_o = ~bank_q;   // Bus always sees the idle bank

endmodule

// ==== src/corr_types_pkg.sv ====
package corr_types_pkg;

   import corr_cfg_pkg::*;

   // --------------------
   // Front end
   // --------------------
   // One-bit sign samples, bit n belongs to antenna n
   typedef struct packed {
      logic [N_ANT-1:0] re;
      logic [N_ANT-1:0] im;
   } ant_sample_t;

   // Sample bits picked for one lane
   typedef struct packed {
      logic re_a;
      logic im_a;
      logic re_b;
      logic im_b;
   } lane_bits_t;

   // Decoded work for one cycle, shared by all lanes
   typedef struct packed {
      logic                  valid;
      logic [SLOT_BITS-1:0]  slot;
      logic                  bank;     // Buffer bank that receives the result
      logic                  clear;    // Start from zero instead of stored sum
      lane_bits_t [LANES-1:0] lane;
   } corr_op_t;

   // --------------------
   // Results and bus
   // --------------------
   typedef logic [ACCUM_BITS-1:0] bus_word_t;

   // Cosine sits in the low half so that bus word 0 is cosine
   typedef struct packed {
      logic signed [ACCUM_BITS-1:0] sin;
      logic signed [ACCUM_BITS-1:0] cos;
   } vis_pair_t;

   // Same buffer word seen by the lane and by the bus port
   typedef union packed {
      vis_pair_t       pair;
      bus_word_t [1:0] word;
   } vis_word_u;

   typedef struct packed {
      logic                 valid;
      logic [SLOT_BITS-1:0] slot;
      logic                 bank;
      vis_word_u            vis;
   } lane_result_t;

   typedef struct packed {
      logic                     stb;   // Single-cycle read request
      logic [BUS_ADDR_BITS-1:0] adr;
   } bus_req_t;

endpackage

// ==== src/correlator_block.sv ====
`timescale 1ns/1ps

module correlator_block (
   input  logic                                 clk_x,
   input  logic                                 rst,
   input  logic                                 en_i,
   input  corr_types_pkg::ant_sample_t          sample_i,
   input  logic                                 sw_i,
   input  corr_types_pkg::bus_req_t             bus_i,
   output logic                                 bus_ack_o,
   output logic [corr_cfg_pkg::ACCUM_BITS-1:0]  bus_dat_o,
   output logic                                 overflow_cos_o,
   output logic                                 overflow_sin_o
);

   import corr_cfg_pkg::*;
   import corr_types_pkg::*;

   corr_op_t      op;                // Decode to every lane
   lane_result_t  res [LANES];       // Lane writes into the buffer
   logic          rd_bank;
   logic [LANES-1:0] ovf_cos;
   logic [LANES-1:0] ovf_sin;

   // --------------------
   // Decode
   // --------------------
   corr_pair_decode corr_pair_decode_inst (
      .clk_x     (clk_x),
      .rst       (rst),
      .en_i      (en_i),
      .sample_i  (sample_i),
      .sw_i      (sw_i),
      .op_o      (op),
      .rd_bank_o (rd_bank)
   );

   // --------------------
   // Correlator lanes
   // --------------------
   for (genvar l = 0; l < LANES; l++) begin : g_lane
      corr_mac_lane #(.LANE(l)) corr_mac_lane_inst (
         .clk_x     (clk_x),
         .rst       (rst),
         .op_i      (op),
         .res_o     (res[l]),
         .ovf_cos_o (ovf_cos[l]),
         .ovf_sin_o (ovf_sin[l])
      );
   end

   // --------------------
   // Visibility buffer
   // --------------------
   vis_buffer vis_buffer_inst (
      .clk_x     (clk_x),
      .rst       (rst),
      .res_i     (res),
      .rd_bank_i (rd_bank),
      .bus_i     (bus_i),
      .bus_ack_o (bus_ack_o),
      .bus_dat_o (bus_dat_o)
   );

   assign overflow_cos_o = |ovf_cos;   // Any lane
   assign overflow_sin_o = |ovf_sin;

endmodule

// ==== src/vis_buffer.sv ====
`timescale 1ns/1ps

module vis_buffer (
   input  logic                                 clk_x,
   input  logic                                 rst,
   input  corr_types_pkg::lane_result_t         res_i [corr_cfg_pkg::LANES],
   input  logic                                 rd_bank_i,   // Inactive bank
   input  corr_types_pkg::bus_req_t             bus_i,
   output logic                                 bus_ack_o,   // One-cycle pulse
   output logic [corr_cfg_pkg::ACCUM_BITS-1:0]  bus_dat_o
);

   import corr_cfg_pkg::*;
   import corr_types_pkg::*;

   // Two banks of one word per slot and lane
   vis_word_u                mem_q [2][MRATE][LANES];

   logic                     stb_q;      // Strobe seen last edge
   logic                     ack_q;      // Word read, select next
   logic [BUS_ADDR_BITS-1:0] adr_q;
   logic                     bank_q;
   logic [SLOT_BITS-1:0]     rd_slot;
   logic [LANE_BITS-1:0]     rd_lane;
   logic                     rd_wsel;    // 0 cosine, 1 sine
   logic                     wsel_q;
   vis_word_u                rd_word_q;

   // --------------------
   // Write side
   // --------------------
   // Every lane may write in the same cycle, each to its own column
   always_ff @(posedge clk_x) begin
      for (int l = 0; l < LANES; l++) begin
         if (res_i[l].valid) begin
            mem_q[res_i[l].bank][res_i[l].slot][l] <= res_i[l].vis;
         end
      end
   end

   // --------------------
   // Bus read port
   // --------------------
   // Address split {slot, lane, word select}
   assign rd_wsel = adr_q[0];
   assign rd_lane = adr_q[LANE_BITS:1];
   assign rd_slot = adr_q[BUS_ADDR_BITS-1 -: SLOT_BITS];

   // Ack pipeline, two edges after the strobe
   always_ff @(posedge clk_x) begin
      if (rst) begin
         stb_q     <= 1'b0;
         ack_q     <= 1'b0;
         bus_ack_o <= 1'b0;
      end else begin
         stb_q     <= bus_i.stb;
         ack_q     <= stb_q;
         bus_ack_o <= ack_q;
      end
   end

   // Capture address and bank with the strobe
   always_ff @(posedge clk_x) begin
      if (bus_i.stb) begin
         adr_q  <= bus_i.adr;
         bank_q <= rd_bank_i;
      end
   end

   // Read the word, then pick one half through the bus view
   always_ff @(posedge clk_x) begin
      rd_word_q <= mem_q[bank_q][rd_slot][rd_lane];
      wsel_q    <= rd_wsel;
      bus_dat_o <= rd_word_q.word[wsel_q];   // Valid with bus_ack_o
   end

endmodule

// ==== tb.f ====
src/corr_cfg_pkg.sv
src/corr_types_pkg.sv
src/corr_pair_decode.sv
src/corr_mac_lane.sv
src/vis_buffer.sv
src/correlator_block.sv
sim/correlator_block_asserts.sv
sim/tb_correlator_block.sv
